// File: list.f
+incdir+include
logic/videoPkg.sv
logic/objectPkg.sv
logic/frameControl.sv
logic/tankRotate.sv
logic/spriteRom.sv
logic/bulletHit.sv
logic/pixelMixer.sv
logic/renderTop.sv
test/render_sva.sv
test/renderTb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module renderTb

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module renderTb -Mdir obj_dir
	./obj_dir/VrenderTb | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: tankSprite.mem
// One word per sprite row, row 0 first
// Column c holds its 3-bit palette index at bits 3c+2:3c
B6DB6DB6DB6DB6D
B2CB2CB2CB2CB2C
924924924924924
6A56A56A56A56A5
492492492492492
69A69A69A69A69A
F88F88F88F88F88
6DB6DB6DB6DB6DB
492492492492492
F88F88F88F88F88
6A56A56A56A56A5
69A69A69A69A69A
6DB6DB6DB6DB6DB
492492492492492
F88F88F88F88F88
6A56A56A56A56A5
924924924924924
B2CB2CB2CB2CB2C
B6DB6DB6DB6DB6D
492492492492492

// File: test/renderTb.sv
`timescale 1ns/1ps
`include "render_defines.svh"

module renderTb;

	localparam int FRAME = `H_TOTAL * `V_TOTAL;
	localparam int WRITE_BUDGET = 64;
	localparam int WATCHDOG_CYCLES = 4 * FRAME + 5 + WRITE_BUDGET * 10 + 100;

	logic CLK;
	logic rstN;
	logic req;
	logic [3:0] regAddr;
	logic [31:0] regData;
	logic ack;
	logic hSync;
	logic vSync;
	logic blankN;
	logic [7:0] Red;
	logic [7:0] Green;
	logic [7:0] Blue;

	logic [59:0] spriteMem [20];
	logic [23:0] palette [8];
	int seed;
	int cyc;
	int errors;
	int checks;

	// Pending model follows host writes and the active model is latched per frame
	int pendX [2];
	int pendY [2];
	bit pendAlive [2];
	int pendSin [2];
	int pendCos [2];
	int pendBX [6];
	int pendBY [6];
	int pendBS [6];
	bit pendBA [6];
	bit pendMaze;
	int actX [2];
	int actY [2];
	bit actAlive [2];
	int actSin [2];
	int actCos [2];
	int actBX [6];
	int actBY [6];
	int actBS [6];
	bit actBA [6];
	bit actMaze;

	renderTop DUT (
		.CLK(CLK), .rstN(rstN), .req(req), .regAddr(regAddr), .regData(regData),
		.ack(ack), .hSync(hSync), .vSync(vSync), .blankN(blankN),
		.Red(Red), .Green(Green), .Blue(Blue)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK)
	begin
		if (rstN)
			cyc++;
	end

	function automatic int tankIndex(int t, int x, int y);
		int dx;
		int dy;
		int rx;
		int ry;
		logic [59:0] rowBits;
		if (!actAlive[t])
			return -1;
		dx = x - actX[t];
		dy = y - actY[t];
		rx = (dx * actCos[t] - dy * actSin[t]) >>> 7;
		ry = (dx * actSin[t] + dy * actCos[t]) >>> 7;
		if (rx < -`TANK_HALF || rx >= `TANK_HALF || ry < -`TANK_HALF || ry >= `TANK_HALF)
			return -1;
		rowBits = spriteMem[ry + `TANK_HALF];
		return int'(rowBits[3 * (rx + `TANK_HALF) +: 3]);
	endfunction

	function automatic logic [23:0] expectPixel(int x, int y);
		int i0;
		int i1;
		int b;
		if (x >= `H_ACTIVE || y >= `V_ACTIVE)
			return 24'h0;
		if (actMaze)
			return {8'(x + y), 8'(x), 8'(y)};
		i0 = tankIndex(0, x, y);
		if (i0 >= 0)
			return (i0 == `TRANSPARENT_IDX) ? `BG_RGB : palette[i0];
		for (b = 0; b < `NUM_BULLETS; b++)
			if (actBA[b] && x >= actBX[b] - actBS[b] && x <= actBX[b] + actBS[b] &&
				y >= actBY[b] - actBS[b] && y <= actBY[b] + actBS[b])
				return 24'h0;
		i1 = tankIndex(1, x, y);
		if (i1 == `TRANSPARENT_IDX)
			return `BG_RGB;
		if (i1 == 4)
			return palette[0];
		if (i1 >= 0)
			return palette[i1];
		return `BG_RGB;
	endfunction

	task automatic checkSignal(input string name, input logic [23:0] got,
		input logic [23:0] exp, input int px, input int py);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error: %s at pixel (%0d,%0d): got %h, expected %h",
				name, px, py, got, exp);
		end
	endtask

	task automatic latchFrame();
		actX = pendX;
		actY = pendY;
		actAlive = pendAlive;
		actSin = pendSin;
		actCos = pendCos;
		actBX = pendBX;
		actBY = pendBY;
		actBS = pendBS;
		actBA = pendBA;
		actMaze = pendMaze;
	endtask

	always @(negedge CLK)
	begin : compareOutputs
		int p;
		int px;
		int py;
		if (cyc < `PIPE_DELAY)
		begin
			checkSignal("RGB", {Red, Green, Blue}, 24'h0, -1, -1);
			checkSignal("blankN", 24'(blankN), 24'h0, -1, -1);
			checkSignal("hSync", 24'(hSync), 24'h1, -1, -1);
			checkSignal("vSync", 24'(vSync), 24'h1, -1, -1);
			checkSignal("ack", 24'(ack), 24'h0, -1, -1);
		end
		else
		begin
			p = cyc - `PIPE_DELAY;
			if (p % FRAME == 0)
				latchFrame();
			px = p % `H_TOTAL;
			py = (p / `H_TOTAL) % `V_TOTAL;
			checkSignal("RGB", {Red, Green, Blue}, expectPixel(px, py), px, py);
			checkSignal("blankN", 24'(blankN),
				24'(px < `H_ACTIVE && py < `V_ACTIVE), px, py);
			checkSignal("hSync", 24'(hSync),
				24'(!(px >= `H_SYNC_START && px < `H_SYNC_END)), px, py);
			checkSignal("vSync", 24'(vSync),
				24'(!(py >= `V_SYNC_START && py < `V_SYNC_END)), px, py);
		end
	end

	task automatic recordWrite(input logic [3:0] addr, input logic [31:0] data);
		int t;
		int b;
		t = int'(addr[1]);
		b = int'(addr) - 4;
		if (addr == 4'd0 || addr == 4'd2)
		begin
			pendAlive[t] = data[20];
			pendY[t] = int'(data[19:10]);
			pendX[t] = int'(data[9:0]);
		end
		else if (addr == 4'd1 || addr == 4'd3)
		begin
			pendSin[t] = int'($signed(data[15:8]));
			pendCos[t] = int'($signed(data[7:0]));
		end
		else if (addr >= 4'd4 && addr <= 4'd9)
		begin
			pendBA[b] = data[24];
			pendBS[b] = int'(data[23:20]);
			pendBY[b] = int'(data[19:10]);
			pendBX[b] = int'(data[9:0]);
		end
		else if (addr == 4'd10)
			pendMaze = data[0];
	endtask

	// Four-phase write with each phase bounded
	task automatic writeReg(input logic [3:0] addr, input logic [31:0] data);
		int waited;
		@(negedge CLK);
		regAddr = addr;
		regData = data;
		req = 1'b1;
		recordWrite(addr, data);
		waited = 0;
		do
		begin
			@(negedge CLK);
			waited++;
		end
		while (!ack && waited < 20);
		assert (ack && waited == 1)
		else
		begin
			errors++;
			$display("Host write to address %0d was not acknowledged one cycle after req",
				addr);
		end
		req = 1'b0;
		waited = 0;
		do
		begin
			@(negedge CLK);
			waited++;
		end
		while (ack && waited < 20);
		assert (!ack && waited == 1)
		else
		begin
			errors++;
			$display("ack did not fall one cycle after req was released");
		end
	endtask

	task automatic writeTank(int t, int x, int y, bit alive, int sinV, int cosV);
		writeReg(4'(2 * t), {11'b0, alive, 10'(y), 10'(x)});
		writeReg(4'(2 * t + 1), {16'b0, 8'(sinV), 8'(cosV)});
	endtask

	task automatic writeBullet(int b, bit act, int size, int x, int y);
		writeReg(4'(4 + b), {7'b0, act, 4'(size), 10'(y), 10'(x)});
	endtask

	task automatic waitMidFrame(int f);
		while (cyc < f * FRAME + 100 * `H_TOTAL)
			@(negedge CLK);
	endtask

	function automatic int randRange(int lo, int span);
		return lo + int'({$random(seed)} % span);
	endfunction

	initial
	begin
		int x0;
		int y0;
		int x1;
		int y1;
		seed = 32'ha8fc4699;
		CLK = 1'b0;
		rstN = 1'b0;
		req = 1'b0;
		regAddr = '0;
		regData = '0;
		cyc = 0;
		errors = 0;
		checks = 0;
		palette = '{24'hFF3131, 24'h312222, 24'h878888, 24'h9B9DAA,
			24'hFFEE00, 24'hFF00D6, 24'h000000, 24'hFFFFFF};
		$readmemh("tankSprite.mem", spriteMem);
		repeat (5) @(negedge CLK);
		rstN = 1'b1;

		// Angles 0 and 90 degrees with bullets on and off the tanks
		waitMidFrame(0);
		x0 = randRange(20, 600);
		y0 = randRange(20, 440);
		x1 = randRange(20, 600);
		y1 = randRange(20, 440);
		writeTank(0, x0, y0, 1'b1, 0, 127);
		writeTank(1, x1, y1, 1'b1, 127, 0);
		writeBullet(0, 1'b1, 3, x0, y0);
		writeBullet(1, 1'b1, 4, x1 + 2, y1);
		writeBullet(2, 1'b1, randRange(0, 16), randRange(0, 640), randRange(0, 480));
		writeBullet(3, 1'b0, 8, randRange(0, 640), randRange(0, 480));
		writeBullet(4, 1'b1, randRange(0, 16), randRange(0, 640), randRange(0, 480));
		writeBullet(5, 1'b1, randRange(0, 16), randRange(0, 640), randRange(0, 480));
		writeReg(4'd12, 32'hFFFF_FFFF);
		writeReg(4'd10, 32'h0);

		// 45 degrees with tank 0 dead
		waitMidFrame(1);
		writeTank(0, x0, y0, 1'b0, 90, 90);
		writeTank(1, randRange(20, 600), randRange(20, 440), 1'b1, 90, 90);

		waitMidFrame(2);
		writeReg(4'd10, 32'h1);

		while (cyc < 4 * FRAME + `PIPE_DELAY)
			@(negedge CLK);
		@(posedge CLK);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 100);
		$display("Watchdog expired before the test sequence finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: test/render_sva.sv
`timescale 1ns/1ps

module renderSva (
	input logic CLK,
	input logic rstN,
	input logic req,
	input logic ack,
	input logic [7:0] Red,
	input logic [7:0] Green,
	input logic [7:0] Blue
);

	ackNeedsReq: assert property (@(posedge CLK) disable iff (!rstN)
		$rose(ack) |-> $past(req))
		else $error("ack rose without a pending request");

	// Host may only release req once ack is up
	reqHeld: assert property (@(posedge CLK) disable iff (!rstN)
		$fell(req) |-> ack)
		else $error("req dropped before ack");

	resetQuiet: assert property (@(posedge CLK)
		!rstN |-> !ack && Red == 8'h0 && Green == 8'h0 && Blue == 8'h0)
		else $error("ack or RGB not cleared during reset");

endmodule

bind renderTop renderSva sva (
	.CLK(CLK), .rstN(rstN), .req(req), .ack(ack),
	.Red(Red), .Green(Green), .Blue(Blue)
);

// File: logic/renderTop.sv
`timescale 1ns/1ps
`include "render_defines.svh"

module renderTop (
	input logic CLK,
	input logic rstN,
	input logic req,
	input objectPkg::regAddr_t regAddr,
	input objectPkg::regData_t regData,
	output logic ack,
	output logic hSync,
	output logic vSync,
	output logic blankN,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue
);
	import videoPkg::*;
	import objectPkg::*;

	coord_t drawX;
	coord_t drawY;
	logic active;
	logic maze;
	coord_t [1:0] tankX;
	coord_t [1:0] tankY;
	logic [1:0] tankAlive;
	trig_t [1:0] tankSin;
	trig_t [1:0] tankCos;
	coord_t [`NUM_BULLETS-1:0] bulletX;
	coord_t [`NUM_BULLETS-1:0] bulletY;
	bulletSize_t [`NUM_BULLETS-1:0] bulletSize;
	logic [`NUM_BULLETS-1:0] bulletActive;
	logic [1:0] inBox;
	logic [4:0] spriteRow [2];
	logic [4:0] spriteCol [2];
	spriteRow_t rowData [2];
	logic bulletHitW;

	frameControl uFrame (
		.CLK(CLK), .rstN(rstN), .req(req), .regAddr(regAddr), .regData(regData),
		.ack(ack), .drawX(drawX), .drawY(drawY), .active(active),
		.hSync(hSync), .vSync(vSync), .blankN(blankN),
		.tankX(tankX), .tankY(tankY), .tankAlive(tankAlive),
		.tankSin(tankSin), .tankCos(tankCos),
		.bulletX(bulletX), .bulletY(bulletY), .bulletSize(bulletSize),
		.bulletActive(bulletActive), .maze(maze)
	);

	tankRotate uRotate0 (
		.CLK(CLK), .rstN(rstN), .drawX(drawX), .drawY(drawY),
		.tankX(tankX[0]), .tankY(tankY[0]), .tankSin(tankSin[0]), .tankCos(tankCos[0]),
		.tankAlive(tankAlive[0]), .inBox(inBox[0]),
		.spriteRow(spriteRow[0]), .spriteCol(spriteCol[0])
	);

	tankRotate uRotate1 (
		.CLK(CLK), .rstN(rstN), .drawX(drawX), .drawY(drawY),
		.tankX(tankX[1]), .tankY(tankY[1]), .tankSin(tankSin[1]), .tankCos(tankCos[1]),
		.tankAlive(tankAlive[1]), .inBox(inBox[1]),
		.spriteRow(spriteRow[1]), .spriteCol(spriteCol[1])
	);

	spriteRom uRom0 (.CLK(CLK), .row(spriteRow[0]), .rowData(rowData[0]));
	spriteRom uRom1 (.CLK(CLK), .row(spriteRow[1]), .rowData(rowData[1]));

	bulletHit uBullets (
		.CLK(CLK), .rstN(rstN), .drawX(drawX), .drawY(drawY),
		.bulletX(bulletX), .bulletY(bulletY), .bulletSize(bulletSize),
		.bulletActive(bulletActive), .hit(bulletHitW)
	);

	pixelMixer uMixer (
		.CLK(CLK), .rstN(rstN), .drawX(drawX), .drawY(drawY),
		.active(active), .maze(maze), .in0(inBox[0]), .in1(inBox[1]),
		.col0(spriteCol[0]), .col1(spriteCol[1]),
		.row0Data(rowData[0]), .row1Data(rowData[1]),
		.bulletHitIn(bulletHitW), .Red(Red), .Green(Green), .Blue(Blue)
	);

endmodule

// File: logic/pixelMixer.sv
`timescale 1ns/1ps
`include "render_defines.svh"

module pixelMixer (
	input logic CLK,
	input logic rstN,
	input videoPkg::coord_t drawX,
	input videoPkg::coord_t drawY,
	input logic active,
	input logic maze,
	input logic in0,
	input logic in1,
	input logic [4:0] col0,
	input logic [4:0] col1,
	input videoPkg::spriteRow_t row0Data,
	input videoPkg::spriteRow_t row1Data,
	input logic bulletHitIn,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue
);
	import videoPkg::*;

	coord_t xD1;
	coord_t xD2;
	coord_t yD1;
	coord_t yD2;
	logic actD1;
	logic actD2;
	logic in0D;
	logic in1D;
	logic [4:0] col0D;
	logic [4:0] col1D;
	palIdx_t idx0;
	palIdx_t idx1;
	palIdx_t team1;
	rgb_t pix;

	always_ff @(posedge CLK)
	begin
		xD1 <= drawX;
		xD2 <= xD1;
		yD1 <= drawY;
		yD2 <= yD1;
		col0D <= col0;
		col1D <= col1;
	end

	assign idx0 = row0Data[3*col0D +: 3];
	assign idx1 = row1Data[3*col1D +: 3];
	// Tank 1 shows its yellow trim in the team red
	assign team1 = (idx1 == 3'd4) ? 3'd0 : idx1;

	always_comb
	begin
		if (!actD2)
			pix = '0;
		else if (maze)
			pix = {8'(xD2 + yD2), xD2[7:0], yD2[7:0]};
		else if (in0D)
			pix = (idx0 == palIdx_t'(`TRANSPARENT_IDX)) ? `BG_RGB : paletteTable[idx0];
		else if (bulletHitIn)
			pix = '0;
		else if (in1D)
			pix = (idx1 == palIdx_t'(`TRANSPARENT_IDX)) ? `BG_RGB : paletteTable[team1];
		else
			pix = `BG_RGB;
	end

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			actD1 <= 1'b0;
			actD2 <= 1'b0;
			in0D <= 1'b0;
			in1D <= 1'b0;
			Red <= '0;
			Green <= '0;
			Blue <= '0;
		end
		else
		begin
			actD1 <= active;
			actD2 <= actD1;
			in0D <= in0;
			in1D <= in1;
			Red <= pix[23:16];
			Green <= pix[15:8];
			Blue <= pix[7:0];
		end
	end

endmodule

// File: logic/bulletHit.sv
`timescale 1ns/1ps
`include "render_defines.svh"

module bulletHit (
	input logic CLK,
	input logic rstN,
	input videoPkg::coord_t drawX,
	input videoPkg::coord_t drawY,
	input videoPkg::coord_t [`NUM_BULLETS-1:0] bulletX,
	input videoPkg::coord_t [`NUM_BULLETS-1:0] bulletY,
	input objectPkg::bulletSize_t [`NUM_BULLETS-1:0] bulletSize,
	input logic [`NUM_BULLETS-1:0] bulletActive,
	output logic hit
);
	import videoPkg::*;

	delta_t dxB [`NUM_BULLETS];
	delta_t dyB [`NUM_BULLETS];
	delta_t sizeB [`NUM_BULLETS];
	logic [`NUM_BULLETS-1:0] boxHit;
	logic [`NUM_BULLETS-1:0] boxReg;

	// Square of half width S around each centre
	always_comb
	begin
		for (int i = 0; i < `NUM_BULLETS; i++)
		begin
			dxB[i] = $signed({1'b0, drawX}) - $signed({1'b0, bulletX[i]});
			dyB[i] = $signed({1'b0, drawY}) - $signed({1'b0, bulletY[i]});
			sizeB[i] = delta_t'({7'b0, bulletSize[i]});
			boxHit[i] = bulletActive[i] && dxB[i] >= -sizeB[i] && dxB[i] <= sizeB[i] &&
				dyB[i] >= -sizeB[i] && dyB[i] <= sizeB[i];
		end
	end

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			boxReg <= '0;
			hit <= 1'b0;
		end
		else
		begin
			boxReg <= boxHit;
			hit <= |boxReg;
		end
	end

endmodule

// File: logic/spriteRom.sv
`timescale 1ns/1ps
`include "render_defines.svh"

module spriteRom (
	input logic CLK,
	input logic [4:0] row,
	output videoPkg::spriteRow_t rowData
);
	import videoPkg::*;

	spriteRow_t rom [`SPRITE_W];

	initial
	begin
		$readmemh("tankSprite.mem", rom);
	end

	// Rows past the sprite read as zero
	always_ff @(posedge CLK)
	begin
		if (row < 5'(`SPRITE_W))
			rowData <= rom[row];
		else
			rowData <= '0;
	end

endmodule

// File: logic/tankRotate.sv
`timescale 1ns/1ps
`include "render_defines.svh"

module tankRotate (
	input logic CLK,
	input logic rstN,
	input videoPkg::coord_t drawX,
	input videoPkg::coord_t drawY,
	input videoPkg::coord_t tankX,
	input videoPkg::coord_t tankY,
	input objectPkg::trig_t tankSin,
	input objectPkg::trig_t tankCos,
	input logic tankAlive,
	output logic inBox,
	output logic [4:0] spriteRow,
	output logic [4:0] spriteCol
);
	import videoPkg::*;

	localparam logic signed [12:0] HALF = 13'(`TANK_HALF);

	delta_t dx;
	delta_t dy;
	logic signed [19:0] prodX;
	logic signed [19:0] prodY;
	logic signed [12:0] rx;
	logic signed [12:0] ry;
	logic signed [12:0] colFull;
	logic signed [12:0] rowFull;

	assign dx = $signed({1'b0, drawX}) - $signed({1'b0, tankX});
	assign dy = $signed({1'b0, drawY}) - $signed({1'b0, tankY});
	assign prodX = dx * tankCos - dy * tankSin;
	assign prodY = dx * tankSin + dy * tankCos;

	// Drop the Q1.7 fraction
	assign rx = prodX[19:7];
	assign ry = prodY[19:7];
	assign colFull = rx + HALF;
	assign rowFull = ry + HALF;

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
			inBox <= 1'b0;
		else
			inBox <= tankAlive && rx >= -HALF && rx < HALF && ry >= -HALF && ry < HALF;
	end

	always_ff @(posedge CLK)
	begin
		spriteRow <= rowFull[4:0];
		spriteCol <= colFull[4:0];
	end

endmodule

// File: logic/frameControl.sv
`timescale 1ns/1ps
`include "render_defines.svh"

module frameControl (
	input logic CLK,
	input logic rstN,
	input logic req,
	input objectPkg::regAddr_t regAddr,
	input objectPkg::regData_t regData,
	output logic ack,
	output videoPkg::coord_t drawX,
	output videoPkg::coord_t drawY,
	output logic active,
	output logic hSync,
	output logic vSync,
	output logic blankN,
	output videoPkg::coord_t [1:0] tankX,
	output videoPkg::coord_t [1:0] tankY,
	output logic [1:0] tankAlive,
	output objectPkg::trig_t [1:0] tankSin,
	output objectPkg::trig_t [1:0] tankCos,
	output videoPkg::coord_t [`NUM_BULLETS-1:0] bulletX,
	output videoPkg::coord_t [`NUM_BULLETS-1:0] bulletY,
	output objectPkg::bulletSize_t [`NUM_BULLETS-1:0] bulletSize,
	output logic [`NUM_BULLETS-1:0] bulletActive,
	output logic maze
);
	import videoPkg::*;
	import objectPkg::*;

	localparam coord_t H_LAST = coord_t'(`H_TOTAL - 1);
	localparam coord_t V_LAST = coord_t'(`V_TOTAL - 1);

	hostState_t state;
	logic lineEnd;
	logic frameEnd;
	logic hSyncNow;
	logic vSyncNow;
	logic hostWrite;
	logic isBullet;
	logic tankSel;
	logic [2:0] bulletSel;
	logic [`PIPE_DELAY-1:0] hDly;
	logic [`PIPE_DELAY-1:0] vDly;
	logic [`PIPE_DELAY-1:0] bDly;

	coord_t [1:0] pendX;
	coord_t [1:0] pendY;
	logic [1:0] pendAlive;
	trig_t [1:0] pendSin;
	trig_t [1:0] pendCos;
	coord_t [`NUM_BULLETS-1:0] pendBX;
	coord_t [`NUM_BULLETS-1:0] pendBY;
	bulletSize_t [`NUM_BULLETS-1:0] pendBS;
	logic [`NUM_BULLETS-1:0] pendBA;
	logic pendMaze;

	assign lineEnd = drawX == H_LAST;
	assign frameEnd = lineEnd && drawY == V_LAST;
	assign active = drawX < coord_t'(`H_ACTIVE) && drawY < coord_t'(`V_ACTIVE);
	assign hSyncNow = !(drawX >= coord_t'(`H_SYNC_START) && drawX < coord_t'(`H_SYNC_END));
	assign vSyncNow = !(drawY >= coord_t'(`V_SYNC_START) && drawY < coord_t'(`V_SYNC_END));

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			drawX <= '0;
			drawY <= '0;
		end
		else if (lineEnd)
		begin
			drawX <= '0;
			drawY <= (drawY == V_LAST) ? '0 : drawY + 1'b1;
		end
		else
			drawX <= drawX + 1'b1;
	end

	// Sync and blank follow the pixel pipeline
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			hDly <= '1;
			vDly <= '1;
			bDly <= '0;
		end
		else
		begin
			hDly <= {hDly[`PIPE_DELAY-2:0], hSyncNow};
			vDly <= {vDly[`PIPE_DELAY-2:0], vSyncNow};
			bDly <= {bDly[`PIPE_DELAY-2:0], active};
		end
	end

	assign hSync = hDly[`PIPE_DELAY-1];
	assign vSync = vDly[`PIPE_DELAY-1];
	assign blankN = bDly[`PIPE_DELAY-1];

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
			state <= HOST_IDLE;
		else
			case (state)
				HOST_IDLE: if (req) state <= HOST_ACK;
				HOST_ACK: if (!req) state <= HOST_RELEASE;
				HOST_RELEASE: state <= HOST_IDLE;
				default: state <= HOST_IDLE;
			endcase
	end

	assign ack = state == HOST_ACK;
	assign hostWrite = state == HOST_IDLE && req;

	// Tank 1 owns addresses 2 and 3
	assign tankSel = regAddr[1];
	assign isBullet = regAddr >= ADDR_BULLET0 &&
		regAddr < ADDR_BULLET0 + regAddr_t'(`NUM_BULLETS);
	assign bulletSel = 3'(regAddr - ADDR_BULLET0);

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			pendX <= '0;
			pendY <= '0;
			pendAlive <= '0;
			pendSin <= '0;
			pendCos <= '0;
			pendBX <= '0;
			pendBY <= '0;
			pendBS <= '0;
			pendBA <= '0;
			pendMaze <= 1'b0;
		end
		else if (hostWrite)
		begin
			case (regAddr)
				ADDR_POS0, ADDR_POS1:
				begin
					pendAlive[tankSel] <= regData[20];
					pendY[tankSel] <= regData[19:10];
					pendX[tankSel] <= regData[9:0];
				end
				ADDR_ANG0, ADDR_ANG1:
				begin
					pendSin[tankSel] <= regData[15:8];
					pendCos[tankSel] <= regData[7:0];
				end
				ADDR_MODE: pendMaze <= regData[0];
				default:
					if (isBullet)
					begin
						pendBA[bulletSel] <= regData[24];
						pendBS[bulletSel] <= regData[23:20];
						pendBY[bulletSel] <= regData[19:10];
						pendBX[bulletSel] <= regData[9:0];
					end
			endcase
		end
	end

	// Swap on the last pixel so (0,0) already sees the new bank
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			tankX <= '0;
			tankY <= '0;
			tankAlive <= '0;
			tankSin <= '0;
			tankCos <= '0;
			bulletX <= '0;
			bulletY <= '0;
			bulletSize <= '0;
			bulletActive <= '0;
			maze <= 1'b0;
		end
		else if (frameEnd)
		begin
			tankX <= pendX;
			tankY <= pendY;
			tankAlive <= pendAlive;
			tankSin <= pendSin;
			tankCos <= pendCos;
			bulletX <= pendBX;
			bulletY <= pendBY;
			bulletSize <= pendBS;
			bulletActive <= pendBA;
			maze <= pendMaze;
		end
	end

endmodule

// File: logic/objectPkg.sv
package objectPkg;

	// Q1.7 where 127 is roughly +1.0
	typedef logic signed [7:0] trig_t;
	typedef logic [3:0] regAddr_t;
	typedef logic [31:0] regData_t;
	typedef logic [3:0] bulletSize_t;

	typedef enum logic [1:0] {
		HOST_IDLE,
		HOST_ACK,
		HOST_RELEASE
	} hostState_t;

	// Position word: alive[20], y[19:10], x[9:0]
	// Angle word: sin[15:8], cos[7:0]
	// Bullet word: active[24], size[23:20], y[19:10], x[9:0]
	localparam regAddr_t ADDR_POS0 = 4'd0;
	localparam regAddr_t ADDR_ANG0 = 4'd1;
	localparam regAddr_t ADDR_POS1 = 4'd2;
	localparam regAddr_t ADDR_ANG1 = 4'd3;
	localparam regAddr_t ADDR_BULLET0 = 4'd4;
	localparam regAddr_t ADDR_MODE = 4'd10;

endpackage

// File: logic/videoPkg.sv
`include "render_defines.svh"

package videoPkg;

	typedef logic [9:0] coord_t;
	typedef logic signed [10:0] delta_t;
	typedef logic [2:0] palIdx_t;
	typedef logic [23:0] rgb_t;

	// Twenty 3-bit indices with column c at bits 3c+2:3c
	typedef logic [3*`SPRITE_W-1:0] spriteRow_t;

	localparam rgb_t paletteTable [8] = '{
		24'hFF3131, 24'h312222, 24'h878888, 24'h9B9DAA,
		24'hFFEE00, 24'hFF00D6, 24'h000000, 24'hFFFFFF
	};

endpackage

// File: include/render_defines.svh
`ifndef RENDER_DEFINES_SVH
`define RENDER_DEFINES_SVH

// Raster
`define H_ACTIVE 640
`define H_TOTAL 800
`define V_ACTIVE 480
`define V_TOTAL 525

// Sync windows are active low and end exclusive
`define H_SYNC_START 656
`define H_SYNC_END 752
`define V_SYNC_START 490
`define V_SYNC_END 492

`define PIPE_DELAY 3

// Tank box and sprite
`define TANK_HALF 10
`define SPRITE_W 20

`define NUM_BULLETS 6
`define TRANSPARENT_IDX 5
`define BG_RGB 24'h555555

`endif
